/* Bender.yml */
package:
  name: int_exec_unit

sources:
  - files:
      - common/intExecPkg.sv
      - src/issueSlot.sv
      - intAlu/bitCount.sv
      - intAlu/intAlu.sv
      - src/resultQueue.sv
      - src/intExecUnit.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/intExecTb.sv

/* common/intExecPkg.sv */
package intExecPkg;

    // Reorder sequence numbers compare by signed difference
    localparam int sqnWidth = 7;
    localparam int tagWidth = 7;

    typedef enum logic [5:0] {
        // Base integer
        opAdd       = 6'h00,
        opSub       = 6'h01,
        opXor       = 6'h02,
        opOr        = 6'h03,
        opAnd       = 6'h04,
        opSll       = 6'h05,
        opSrl       = 6'h06,
        opSra       = 6'h07,
        opSlt       = 6'h08,
        opSltu      = 6'h09,
        opLui       = 6'h0a,
        opAuipc     = 6'h0b,
        // Zba / Zbb subset
        opSh1add    = 6'h10,
        opSh2add    = 6'h11,
        opSh3add    = 6'h12,
        opAndn      = 6'h13,
        opOrn       = 6'h14,
        opXnor      = 6'h15,
        opSextB     = 6'h16,
        opSextH     = 6'h17,
        opZextH     = 6'h18,
        opClz       = 6'h19,
        opCtz       = 6'h1a,
        opCpop      = 6'h1b,
        opOrcB      = 6'h1c,
        opMin       = 6'h1d,
        opMinu      = 6'h1e,
        opMax       = 6'h1f,
        opMaxu      = 6'h20,
        opRev8      = 6'h21,
        // Control flow
        opJal       = 6'h28,
        opJalr      = 6'h29,
        opBeq       = 6'h2a,
        opBne       = 6'h2b,
        opBlt       = 6'h2c,
        opBge       = 6'h2d,
        opBltu      = 6'h2e,
        opBgeu      = 6'h2f,
        opUndefined = 6'h3f
    } intOpcode;

    typedef enum logic [1:0] {
        flagsNone   = 2'd0,
        flagsExcept = 2'd1
    } resFlags;

endpackage

/* intAlu/bitCount.sv */
`timescale 1ns/1ps

module bitCount (
    input  logic [31:0] operand,
    input  logic countTrailing,
    output logic [5:0] zeroCount,
    output logic [5:0] popCount
);

    logic [31:0] scanWord;

    // Trailing zeros are leading zeros of the mirrored word
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            scanWord[i] = countTrailing ? operand[31-i] : operand[i];
        end
    end

    // Highest set bit wins since the scan runs upward
    always_comb begin
        zeroCount = 6'd32;
        for (int i = 0; i < 32; i++) begin
            if (scanWord[i]) begin
                zeroCount = 6'(31 - i);
            end
        end
    end

    always_comb begin
        popCount = 6'd0;
        for (int i = 0; i < 32; i++) begin
            popCount = popCount + 6'(operand[i]);
        end
    end

endmodule

/* intAlu/intAlu.sv */
`timescale 1ns/1ps

module intAlu (
    input  logic clk,
    input  logic rst,
    input  logic slotValid,
    output logic slotReady,
    input  intExecPkg::intOpcode slotOpcode,
    input  logic [31:0] slotSrcA,
    input  logic [31:0] slotSrcB,
    input  logic [31:0] slotImm,
    input  logic [31:0] slotPc,
    input  logic slotCompressed,
    input  logic [intExecPkg::sqnWidth-1:0] slotSqn,
    input  logic [intExecPkg::tagWidth-1:0] slotTagDst,
    input  logic slotBranchPred,
    input  logic flush,
    input  logic [intExecPkg::sqnWidth-1:0] flushSqn,
    output logic aluValid,
    input  logic aluReady,
    output logic [31:0] aluResult,
    output logic [intExecPkg::tagWidth-1:0] aluTag,
    output intExecPkg::resFlags aluFlags,
    output logic [intExecPkg::sqnWidth-1:0] aluSqn,
    output logic redirectValid,
    output logic [31:0] redirectPc,
    output logic [intExecPkg::sqnWidth-1:0] redirectSqn
);

    import intExecPkg::*;

    logic [31:0] diff;
    logic lessThan;
    logic lessThanU;
    logic [31:0] fallThrough;
    logic [31:0] branchTarget;
    logic [5:0] zeroCount;
    logic [5:0] popCount;
    logic [31:0] result;
    resFlags flags;
    logic isBranch;
    logic branchTaken;
    logic needRedirect;
    logic [31:0] targetPc;
    logic signed [sqnWidth-1:0] sqnAge;
    logic take;
    logic survive;

    bitCount counter (
        .operand      (slotSrcA),
        .countTrailing(slotOpcode == opCtz),
        .zeroCount    (zeroCount),
        .popCount     (popCount)
    );

    // Comparisons shared by slt, min/max and the branches
    assign diff = slotSrcA - slotSrcB;
    assign lessThan = $signed(slotSrcA) < $signed(slotSrcB);
    assign lessThanU = slotSrcA < slotSrcB;

    assign fallThrough = slotPc + (slotCompressed ? 32'd2 : 32'd4);
    assign branchTarget = slotPc + {{19{slotImm[12]}}, slotImm[12:0]};

    always_comb begin
        flags = flagsNone;
        case (slotOpcode)
            opAdd:    result = slotSrcA + slotSrcB;
            opSub:    result = diff;
            opXor:    result = slotSrcA ^ slotSrcB;
            opOr:     result = slotSrcA | slotSrcB;
            opAnd:    result = slotSrcA & slotSrcB;
            opSll:    result = slotSrcA << slotSrcB[4:0];
            opSrl:    result = slotSrcA >> slotSrcB[4:0];
            opSra:    result = $unsigned($signed(slotSrcA) >>> slotSrcB[4:0]);
            opSlt:    result = {31'b0, lessThan};
            opSltu:   result = {31'b0, lessThanU};
            opLui:    result = slotImm;
            opAuipc:  result = slotPc + slotImm;
            opSh1add: result = slotSrcB + (slotSrcA << 1);
            opSh2add: result = slotSrcB + (slotSrcA << 2);
            opSh3add: result = slotSrcB + (slotSrcA << 3);
            opAndn:   result = slotSrcA & ~slotSrcB;
            opOrn:    result = slotSrcA | ~slotSrcB;
            opXnor:   result = ~(slotSrcA ^ slotSrcB);
            opSextB:  result = {{24{slotSrcA[7]}}, slotSrcA[7:0]};
            opSextH:  result = {{16{slotSrcA[15]}}, slotSrcA[15:0]};
            opZextH:  result = {16'b0, slotSrcA[15:0]};
            opClz,
            opCtz:    result = {26'b0, zeroCount};
            opCpop:   result = {26'b0, popCount};
            opOrcB:   result = {{8{|slotSrcA[31:24]}}, {8{|slotSrcA[23:16]}},
                                {8{|slotSrcA[15:8]}}, {8{|slotSrcA[7:0]}}};
            opMin:    result = lessThan ? slotSrcA : slotSrcB;
            opMinu:   result = lessThanU ? slotSrcA : slotSrcB;
            opMax:    result = lessThan ? slotSrcB : slotSrcA;
            opMaxu:   result = lessThanU ? slotSrcB : slotSrcA;
            opRev8:   result = {slotSrcA[7:0], slotSrcA[15:8], slotSrcA[23:16], slotSrcA[31:24]};
            // Link address
            opJal,
            opJalr:   result = fallThrough;
            opUndefined: begin
                result = 32'b0;
                flags = flagsExcept;
            end
            default:  result = 32'b0;
        endcase
    end

    assign isBranch = slotOpcode inside {opBeq, opBne, opBlt, opBge, opBltu, opBgeu};

    always_comb begin
        case (slotOpcode)
            opBeq:   branchTaken = diff == 32'b0;
            opBne:   branchTaken = diff != 32'b0;
            opBlt:   branchTaken = lessThan;
            opBge:   branchTaken = !lessThan;
            opBltu:  branchTaken = lessThanU;
            opBgeu:  branchTaken = !lessThanU;
            default: branchTaken = 1'b0;
        endcase

        needRedirect = 1'b0;
        targetPc = fallThrough;
        if (isBranch) begin
            needRedirect = branchTaken != slotBranchPred;
            targetPc = branchTaken ? branchTarget : fallThrough;
        end else if (slotOpcode == opJal) begin
            needRedirect = !slotBranchPred;
            targetPc = slotPc + slotImm;
        end else if (slotOpcode == opJalr) begin
            // Register jumps are never predicted
            needRedirect = 1'b1;
            targetPc = (slotSrcA + slotSrcB) & ~32'd1;
        end
    end

    // Positive age means younger than the flush point
    assign sqnAge = slotSqn - flushSqn;
    assign survive = !flush || sqnAge <= 0;

    assign slotReady = !aluValid || aluReady;
    assign take = slotValid && slotReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            aluValid <= 1'b0;
            redirectValid <= 1'b0;
        end else begin
            if (take) begin
                aluValid <= survive;
            end else if (aluReady) begin
                aluValid <= 1'b0;
            end
            redirectValid <= take && survive && needRedirect;
        end
    end

    always_ff @(posedge clk) begin
        if (take && survive) begin
            aluResult   <= result;
            aluTag      <= slotTagDst;
            aluFlags    <= flags;
            aluSqn      <= slotSqn;
            redirectPc  <= targetPc;
            redirectSqn <= slotSqn;
        end
    end

    redirectWithResult: assert property (@(posedge clk) disable iff (rst)
        redirectValid |-> aluValid && aluSqn == redirectSqn);

endmodule

/* src/intExecUnit.sv */
`timescale 1ns/1ps

module intExecUnit #(
    parameter int queueDepth = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    output logic inReady,
    input  intExecPkg::intOpcode inOpcode,
    input  logic [31:0] inSrcA,
    input  logic [31:0] inSrcB,
    input  logic [31:0] inImm,
    input  logic [31:0] inPc,
    input  logic inCompressed,
    input  logic [intExecPkg::sqnWidth-1:0] inSqn,
    input  logic [intExecPkg::tagWidth-1:0] inTagDst,
    input  logic inBranchPred,
    input  logic flush,
    input  logic [intExecPkg::sqnWidth-1:0] flushSqn,
    output logic resValid,
    input  logic resReady,
    output logic [31:0] resData,
    output logic [intExecPkg::tagWidth-1:0] resTag,
    output intExecPkg::resFlags resFlags,
    output logic [intExecPkg::sqnWidth-1:0] resSqn,
    output logic redirectValid,
    output logic [31:0] redirectPc,
    output logic [intExecPkg::sqnWidth-1:0] redirectSqn
);

    import intExecPkg::*;

    logic slotValid;
    logic slotReady;
    intOpcode slotOpcode;
    logic [31:0] slotSrcA;
    logic [31:0] slotSrcB;
    logic [31:0] slotImm;
    logic [31:0] slotPc;
    logic slotCompressed;
    logic [sqnWidth-1:0] slotSqn;
    logic [tagWidth-1:0] slotTagDst;
    logic slotBranchPred;

    logic aluValid;
    logic aluReady;
    logic [31:0] aluResult;
    logic [tagWidth-1:0] aluTag;
    intExecPkg::resFlags aluFlags;
    logic [sqnWidth-1:0] aluSqn;

    issueSlot slot (
        .clk           (clk),
        .rst           (rst),
        .inValid       (inValid),
        .inReady       (inReady),
        .inOpcode      (inOpcode),
        .inSrcA        (inSrcA),
        .inSrcB        (inSrcB),
        .inImm         (inImm),
        .inPc          (inPc),
        .inCompressed  (inCompressed),
        .inSqn         (inSqn),
        .inTagDst      (inTagDst),
        .inBranchPred  (inBranchPred),
        .slotValid     (slotValid),
        .slotReady     (slotReady),
        .slotOpcode    (slotOpcode),
        .slotSrcA      (slotSrcA),
        .slotSrcB      (slotSrcB),
        .slotImm       (slotImm),
        .slotPc        (slotPc),
        .slotCompressed(slotCompressed),
        .slotSqn       (slotSqn),
        .slotTagDst    (slotTagDst),
        .slotBranchPred(slotBranchPred)
    );

    intAlu alu (
        .clk           (clk),
        .rst           (rst),
        .slotValid     (slotValid),
        .slotReady     (slotReady),
        .slotOpcode    (slotOpcode),
        .slotSrcA      (slotSrcA),
        .slotSrcB      (slotSrcB),
        .slotImm       (slotImm),
        .slotPc        (slotPc),
        .slotCompressed(slotCompressed),
        .slotSqn       (slotSqn),
        .slotTagDst    (slotTagDst),
        .slotBranchPred(slotBranchPred),
        .flush         (flush),
        .flushSqn      (flushSqn),
        .aluValid      (aluValid),
        .aluReady      (aluReady),
        .aluResult     (aluResult),
        .aluTag        (aluTag),
        .aluFlags      (aluFlags),
        .aluSqn        (aluSqn),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .redirectSqn   (redirectSqn)
    );

    resultQueue #(
        .queueDepth(queueDepth)
    ) queue (
        .clk      (clk),
        .rst      (rst),
        .aluValid (aluValid),
        .aluReady (aluReady),
        .aluResult(aluResult),
        .aluTag   (aluTag),
        .aluFlags (aluFlags),
        .aluSqn   (aluSqn),
        .resValid (resValid),
        .resReady (resReady),
        .resData  (resData),
        .resTag   (resTag),
        .resFlags (resFlags),
        .resSqn   (resSqn)
    );

endmodule

/* src/issueSlot.sv */
`timescale 1ns/1ps

module issueSlot (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    output logic inReady,
    input  intExecPkg::intOpcode inOpcode,
    input  logic [31:0] inSrcA,
    input  logic [31:0] inSrcB,
    input  logic [31:0] inImm,
    input  logic [31:0] inPc,
    input  logic inCompressed,
    input  logic [intExecPkg::sqnWidth-1:0] inSqn,
    input  logic [intExecPkg::tagWidth-1:0] inTagDst,
    input  logic inBranchPred,
    output logic slotValid,
    input  logic slotReady,
    output intExecPkg::intOpcode slotOpcode,
    output logic [31:0] slotSrcA,
    output logic [31:0] slotSrcB,
    output logic [31:0] slotImm,
    output logic [31:0] slotPc,
    output logic slotCompressed,
    output logic [intExecPkg::sqnWidth-1:0] slotSqn,
    output logic [intExecPkg::tagWidth-1:0] slotTagDst,
    output logic slotBranchPred
);

    logic accept;

    // Refill in the same cycle the held op leaves
    assign inReady = !slotValid || slotReady;
    assign accept = inValid && inReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= 1'b0;
        end else if (accept) begin
            slotValid <= 1'b1;
        end else if (slotReady) begin
            slotValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slotOpcode     <= inOpcode;
            slotSrcA       <= inSrcA;
            slotSrcB       <= inSrcB;
            slotImm        <= inImm;
            slotPc         <= inPc;
            slotCompressed <= inCompressed;
            slotSqn        <= inSqn;
            slotTagDst     <= inTagDst;
            slotBranchPred <= inBranchPred;
        end
    end

    holdStable: assert property (@(posedge clk) disable iff (rst)
        slotValid && !slotReady |=> $stable({slotOpcode, slotSrcA, slotSrcB, slotImm, slotPc,
                                             slotCompressed, slotSqn, slotTagDst,
                                             slotBranchPred}));

endmodule

/* src/resultQueue.sv */
`timescale 1ns/1ps

module resultQueue #(
    parameter int queueDepth = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic aluValid,
    output logic aluReady,
    input  logic [31:0] aluResult,
    input  logic [intExecPkg::tagWidth-1:0] aluTag,
    input  intExecPkg::resFlags aluFlags,
    input  logic [intExecPkg::sqnWidth-1:0] aluSqn,
    output logic resValid,
    input  logic resReady,
    output logic [31:0] resData,
    output logic [intExecPkg::tagWidth-1:0] resTag,
    output intExecPkg::resFlags resFlags,
    output logic [intExecPkg::sqnWidth-1:0] resSqn
);

    import intExecPkg::*;

    localparam int ptrWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int countWidth = $clog2(queueDepth + 1);

    logic [31:0] dataMem [queueDepth];
    logic [tagWidth-1:0] tagMem [queueDepth];
    intExecPkg::resFlags flagsMem [queueDepth];
    logic [sqnWidth-1:0] sqnMem [queueDepth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [countWidth-1:0] count;
    logic push;
    logic pop;
    logic full;

    assign full = count == countWidth'(queueDepth);
    assign resValid = count != '0;
    assign pop = resValid && resReady;
    // A full queue still takes a result when its head leaves
    assign aluReady = !full || pop;
    assign push = aluValid && aluReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ptrWidth'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrWidth'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + countWidth'(push) - countWidth'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            dataMem[wrPtr]  <= aluResult;
            tagMem[wrPtr]   <= aluTag;
            flagsMem[wrPtr] <= aluFlags;
            sqnMem[wrPtr]   <= aluSqn;
        end
    end

    assign resData  = dataMem[rdPtr];
    assign resTag   = tagMem[rdPtr];
    assign resFlags = flagsMem[rdPtr];
    assign resSqn   = sqnMem[rdPtr];

    noOverflow: assert property (@(posedge clk) disable iff (rst)
        full && !pop |-> !push);

endmodule

/* verif/aluRefModel.svh */
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Expected result, flags and redirect of one micro-op, worked out from the ISA rules
function automatic void predictOp(
    input  intOpcode op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [31:0] imm,
    input  logic [31:0] pc,
    input  logic compressed,
    input  logic pred,
    output logic [31:0] res,
    output resFlags flags,
    output logic redirect,
    output logic [31:0] target
);
    logic [31:0] link;
    logic taken;
    int n;
    int i;

    link = pc + (compressed ? 32'd2 : 32'd4);
    res = 32'b0;
    flags = flagsNone;
    redirect = 1'b0;
    target = link;
    taken = 1'b0;
    n = 0;
    case (op)
        opAdd:    res = a + b;
        opSub:    res = a - b;
        opXor:    res = a ^ b;
        opOr:     res = a | b;
        opAnd:    res = a & b;
        opSll:    res = a << b[4:0];
        opSrl:    res = a >> b[4:0];
        opSra:    res = $signed(a) >>> b[4:0];
        opSlt:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        opSltu:   res = (a < b) ? 32'd1 : 32'd0;
        opLui:    res = imm;
        opAuipc:  res = pc + imm;
        opSh1add: res = b + a * 2;
        opSh2add: res = b + a * 4;
        opSh3add: res = b + a * 8;
        opAndn:   res = a & ~b;
        opOrn:    res = a | ~b;
        opXnor:   res = a ~^ b;
        opSextB:  res = 32'($signed(a[7:0]));
        opSextH:  res = 32'($signed(a[15:0]));
        opZextH:  res = a & 32'h0000_ffff;
        opClz: begin
            while (n < 32 && !a[31-n]) n++;
            res = n;
        end
        opCtz: begin
            while (n < 32 && !a[n]) n++;
            res = n;
        end
        opCpop: begin
            for (i = 0; i < 32; i++) res = res + a[i];
        end
        opOrcB: begin
            for (i = 0; i < 4; i++) res[8*i +: 8] = (a[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
        end
        opMin:    res = ($signed(a) < $signed(b)) ? a : b;
        opMinu:   res = (a < b) ? a : b;
        opMax:    res = ($signed(a) > $signed(b)) ? a : b;
        opMaxu:   res = (a > b) ? a : b;
        opRev8: begin
            for (i = 0; i < 4; i++) res[8*i +: 8] = a[8*(3-i) +: 8];
        end
        opJal: begin
            res = link;
            redirect = !pred;
            target = pc + imm;
        end
        opJalr: begin
            res = link;
            redirect = 1'b1;
            target = (a + b) & 32'hffff_fffe;
        end
        opBeq:    taken = a == b;
        opBne:    taken = a != b;
        opBlt:    taken = $signed(a) < $signed(b);
        opBge:    taken = $signed(a) >= $signed(b);
        opBltu:   taken = a < b;
        opBgeu:   taken = a >= b;
        opUndefined: flags = flagsExcept;
        default:  res = 32'b0;
    endcase

    // Conditional branches redirect on a wrong prediction
    if (op inside {opBeq, opBne, opBlt, opBge, opBltu, opBgeu}) begin
        redirect = taken != pred;
        target = taken ? pc + 32'($signed(imm[12:0])) : link;
    end
endfunction

`endif

/* verif/intExecTb.sv */
`timescale 1ns/1ps

module intExecTb;

    import intExecPkg::*;

    `include "aluRefModel.svh"

    localparam int numAlu = 40;
    localparam int numBitOps = 18 * 3 + 1;
    localparam int numCtrl = 40;
    localparam int numStress = 60;
    localparam int numFlush = 30;
    localparam int totalOps = numAlu + numBitOps + numCtrl + numStress + numFlush;
    localparam int cycleLimit = 10 * totalOps + 200;

    logic clk;
    logic rst;
    logic inValid;
    logic inReady;
    intOpcode inOpcode;
    logic [31:0] inSrcA;
    logic [31:0] inSrcB;
    logic [31:0] inImm;
    logic [31:0] inPc;
    logic inCompressed;
    logic [sqnWidth-1:0] inSqn;
    logic [tagWidth-1:0] inTagDst;
    logic inBranchPred;
    logic flush;
    logic [sqnWidth-1:0] flushSqn;
    logic resValid;
    logic resReady;
    logic [31:0] resData;
    logic [tagWidth-1:0] resTag;
    resFlags outFlags;
    logic [sqnWidth-1:0] resSqn;
    logic redirectValid;
    logic [31:0] redirectPc;
    logic [sqnWidth-1:0] redirectSqn;

    // Result entry is {data, flags, tag, sqn}
    // Redirect entry is {pc, sqn}
    logic [47:0] expResults[$];
    logic [38:0] expRedirects[$];
    logic [sqnWidth-1:0] nextSqn;
    logic randomReady;
    logic prevStall = 1'b0;
    logic [47:0] prevHead;
    int cycleCount = 0;

    intOpcode aluOps[12] = '{opAdd, opSub, opXor, opOr, opAnd, opSll, opSrl, opSra,
                             opSlt, opSltu, opLui, opAuipc};
    intOpcode bitOps[18] = '{opSh1add, opSh2add, opSh3add, opAndn, opOrn, opXnor, opSextB,
                             opSextH, opZextH, opClz, opCtz, opCpop, opOrcB, opMin, opMinu,
                             opMax, opMaxu, opRev8};
    intOpcode ctrlOps[8] = '{opJal, opJalr, opBeq, opBne, opBlt, opBge, opBltu, opBgeu};

    intExecUnit #(
        .queueDepth(2)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .inValid      (inValid),
        .inReady      (inReady),
        .inOpcode     (inOpcode),
        .inSrcA       (inSrcA),
        .inSrcB       (inSrcB),
        .inImm        (inImm),
        .inPc         (inPc),
        .inCompressed (inCompressed),
        .inSqn        (inSqn),
        .inTagDst     (inTagDst),
        .inBranchPred (inBranchPred),
        .flush        (flush),
        .flushSqn     (flushSqn),
        .resValid     (resValid),
        .resReady     (resReady),
        .resData      (resData),
        .resTag       (resTag),
        .resFlags     (outFlags),
        .resSqn       (resSqn),
        .redirectValid(redirectValid),
        .redirectPc   (redirectPc),
        .redirectSqn  (redirectSqn)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            abortRun($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                               $time, what, got, expected));
        end
    endtask

    function automatic logic isYounger(input logic [sqnWidth-1:0] sqn,
                                       input logic [sqnWidth-1:0] point);
        logic signed [sqnWidth-1:0] age;
        age = sqn - point;
        return age > 0;
    endfunction

    function automatic intOpcode pickOpcode();
        case ($urandom_range(2, 0))
            0: return aluOps[$urandom_range(11, 0)];
            1: return bitOps[$urandom_range(17, 0)];
            default: return ctrlOps[$urandom_range(7, 0)];
        endcase
    endfunction

    // Called on a falling edge and returns on the falling edge after the handshake
    task automatic issueOp(input intOpcode op, input logic [31:0] a, input logic [31:0] b);
        inOpcode = op;
        inSrcA = a;
        inSrcB = b;
        inImm = $urandom;
        inPc = $urandom & 32'hffff_fffe;
        inCompressed = 1'($urandom_range(1, 0));
        inBranchPred = 1'($urandom_range(1, 0));
        inSqn = nextSqn;
        inTagDst = 7'($urandom);
        inValid = 1'b1;
        nextSqn = nextSqn + 1'b1;
        @(posedge clk);
        while (!inReady) @(posedge clk);
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic waitDrain();
        while (expResults.size() != 0 || expRedirects.size() != 0) @(negedge clk);
    endtask

    always @(negedge clk) begin
        resReady = randomReady ? 1'($urandom_range(1, 0)) : 1'b1;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            abortRun($sformatf("test timed out after %0d cycles", cycleCount));
        end
    end

    // Comparison process samples at the rising edge
    always @(posedge clk) begin
        logic [31:0] expRes;
        resFlags expFlags;
        logic expRedirect;
        logic [31:0] expTarget;
        logic [47:0] entry;
        logic [38:0] jump;
        if (!rst) begin
            if (inValid && inReady) begin
                predictOp(inOpcode, inSrcA, inSrcB, inImm, inPc, inCompressed, inBranchPred,
                          expRes, expFlags, expRedirect, expTarget);
                if (!(flush && isYounger(inSqn, flushSqn))) begin
                    expResults.push_back({expRes, expFlags, inTagDst, inSqn});
                    if (expRedirect) expRedirects.push_back({expTarget, inSqn});
                end
            end
            if (prevStall) begin
                checkValue("resValid while stalled", resValid, 1'b1);
                checkValue("held result", resData, prevHead[47:16]);
                checkValue("held tag", resTag, prevHead[13:7]);
                checkValue("held sqn", resSqn, prevHead[6:0]);
            end
            prevStall = resValid && !resReady;
            prevHead = {resData, outFlags, resTag, resSqn};
            if (resValid && resReady) begin
                if (expResults.size() == 0) begin
                    abortRun("a result came out with no micro-op pending");
                end else begin
                    entry = expResults.pop_front();
                    checkValue("resData", resData, entry[47:16]);
                    checkValue("resFlags", 32'(outFlags), 32'(entry[15:14]));
                    checkValue("resTag", resTag, entry[13:7]);
                    checkValue("resSqn", resSqn, entry[6:0]);
                end
            end
            if (redirectValid) begin
                if (expRedirects.size() == 0) begin
                    abortRun("a redirect came out that no branch called for");
                end else begin
                    jump = expRedirects.pop_front();
                    checkValue("redirectPc", redirectPc, jump[38:7]);
                    checkValue("redirectSqn", redirectSqn, jump[6:0]);
                end
            end
        end
    end

    initial begin
        logic [31:0] a;
        void'($urandom(32'h564a_dc67));
        rst = 1'b1;
        inValid = 1'b0;
        inOpcode = opAdd;
        inSrcA = '0;
        inSrcB = '0;
        inImm = '0;
        inPc = '0;
        inCompressed = 1'b0;
        inSqn = '0;
        inTagDst = '0;
        inBranchPred = 1'b0;
        flush = 1'b0;
        flushSqn = '0;
        resReady = 1'b1;
        randomReady = 1'b0;
        nextSqn = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkValue("resValid after reset", resValid, 1'b0);
        checkValue("redirectValid after reset", redirectValid, 1'b0);
        checkValue("inReady after reset", inReady, 1'b1);

        for (int i = 0; i < numAlu; i++) issueOp(aluOps[$urandom_range(11, 0)], $urandom, $urandom);

        // Counts get the zero and all-ones corner operands
        foreach (bitOps[i]) begin
            issueOp(bitOps[i], 32'h0, $urandom);
            issueOp(bitOps[i], 32'hffff_ffff, $urandom);
            issueOp(bitOps[i], $urandom, $urandom);
        end
        issueOp(opUndefined, $urandom, $urandom);

        for (int i = 0; i < numCtrl; i++) begin
            a = $urandom;
            issueOp(ctrlOps[$urandom_range(7, 0)], a, ($urandom_range(3, 0) == 0) ? a : $urandom);
        end

        randomReady = 1'b1;
        for (int i = 0; i < numStress; i++) issueOp(pickOpcode(), $urandom, $urandom);
        waitDrain();
        randomReady = 1'b0;

        flushSqn = 7'($urandom);
        flush = 1'b1;
        for (int i = 0; i < numFlush - 1; i++) begin
            nextSqn = flushSqn + 7'($urandom_range(16, 0)) - 7'd8;
            issueOp(pickOpcode(), $urandom, $urandom);
        end
        // An older op last marks the flush phase as drained
        nextSqn = flushSqn - 7'd1;
        issueOp(pickOpcode(), $urandom, $urandom);
        waitDrain();
        flush = 1'b0;

        repeat (4) @(negedge clk);
        if (expResults.size() != 0 || expRedirects.size() != 0) begin
            abortRun("some expected results never came out of the pipe");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+verif
common/intExecPkg.sv
src/issueSlot.sv
intAlu/bitCount.sv
intAlu/intAlu.sv
src/resultQueue.sv
src/intExecUnit.sv
verif/intExecTb.sv
